/* compile.f */
+incdir+src
src/ebusPkg.sv
src/aprUnit.sv
src/piUnit.sv
src/ebusMux.sv
src/ebusTop.sv
testbench/ebusTb.sv

/* run.sh */
#!/bin/sh
# Build the EBUS testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module ebusTb -o simEbus

status=0
./obj_dir/simEbus > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation FAILED" sim.log; then
  echo "run.sh: simulation failed, see sim.log"
  exit 1
fi
echo "run.sh: simulation finished cleanly"
exit 0

/* src/aprUnit.sv */
`timescale 1ns/1ps
`include "ebus_macros.svh"

module aprUnit
  import ebusPkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  ebusCmdT                   cmd,
  input  logic                      cmdStrobe,
  input  logic [0:`APR_ERR_COUNT-1] errIn,
  output ebusDriverT                aprDriver,
  output logic                      aprInt,
  output logic [0:2]                aprLevel
);

  // Sticky error flags and the mask that lets them interrupt
  logic [0:`APR_ERR_COUNT-1] errFlags;
  logic [0:`APR_ERR_COUNT-1] errEnable;
  logic [0:`APR_ERR_COUNT-1] clearMask;

  logic     writeHit;
  logic     readHit;
  ebusWordT readWord;
  logic     respDriving;
  ebusWordT respData;

  assign writeHit = cmdStrobe && (cmd.op == opWrite) && (cmd.unit == `UNIT_APR);
  assign readHit  = cmdStrobe && (cmd.op == opRead) && (cmd.unit == `UNIT_APR);

  // Register 0 is write-one-to-clear over the flag field in bits 30 to 35
  assign clearMask = (writeHit && cmd.regSel == 2'd0) ?
                     cmd.data[`EBUS_WIDTH-`APR_ERR_COUNT +: `APR_ERR_COUNT] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      errFlags <= '0;
    end else begin
      // An error arriving in the clear cycle keeps its flag set
      errFlags <= (errFlags & ~clearMask) | errIn;
    end
  end

  // Register 1 carries the enable mask up front and the level at the low end
  always_ff @(posedge clk) begin
    if (reset) begin
      errEnable <= '0;
      aprLevel  <= '0;
    end else if (writeHit && cmd.regSel == 2'd1) begin
      errEnable <= cmd.data[0 +: `APR_ERR_COUNT];
      aprLevel  <= cmd.data[`EBUS_WIDTH-3 +: 3];
    end
  end

  assign aprInt = |(errFlags & errEnable);

  always_comb begin
    readWord = '0;
    case (cmd.regSel)
      2'd0: readWord[`EBUS_WIDTH-`APR_ERR_COUNT +: `APR_ERR_COUNT] = errFlags;
      2'd1: begin
        readWord[0 +: `APR_ERR_COUNT] = errEnable;
        readWord[`EBUS_WIDTH-3 +: 3]  = aprLevel;
      end
      default: readWord = '0;
    endcase
  end

  // The response lives on the bus for the single cycle after the read strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      respDriving <= 1'b0;
    end else begin
      respDriving <= readHit;
    end
  end

  always_ff @(posedge clk) begin
    if (readHit) begin
      respData <= readWord;
    end
  end

  assign aprDriver = '{driving: respDriving, data: respData};

  // Every APR read strobe on the command port gets exactly one response cycle
  aprRespFollowsRead: assert property (@(posedge clk) disable iff (reset)
    aprDriver.driving == $past(cmdStrobe && cmd.op == opRead && cmd.unit == `UNIT_APR))
    else $error("aprUnit EBUS response does not match the APR read on the previous edge");

endmodule

/* src/ebusMux.sv */
`timescale 1ns/1ps

module ebusMux
  import ebusPkg::*;
(
  input  ebusDriverT aprDriver,
  input  ebusDriverT piDriver,
  output ebusWordT   ebusData,
  output logic       ebusValid,
  input  logic       clk
);

  // Fixed priority, APR ahead of PI
  // An idle bus reads as zero so that stale driver data never leaks out
  always_comb begin
    if (aprDriver.driving) begin
      ebusData = aprDriver.data;
    end else if (piDriver.driving) begin
      ebusData = piDriver.data;
    end else begin
      ebusData = '0;
    end
  end

  assign ebusValid = aprDriver.driving | piDriver.driving;

  // Units decode disjoint codes, so two drivers at once means a decode fault
  // in one of them and the priority chain would be hiding it
  noDriverContention: assert property (@(posedge clk)
    !(aprDriver.driving && piDriver.driving))
    else $error("EBUS contention between the APR and PI drivers");

endmodule

/* src/ebusPkg.sv */
`include "ebus_macros.svh"

package ebusPkg;

  // One EBUS word in the machine's big-endian bit order
  typedef logic [0:`EBUS_WIDTH-1] ebusWordT;

  // What the command strobe asks the addressed unit to do
  typedef enum logic [1:0] {
    opNone  = 2'd0,
    opRead  = 2'd1,
    opWrite = 2'd2
  } ebusOpT;

  // Command seen by every unit on the bus
  // Each unit compares unit against its own code and ignores the rest
  typedef struct packed {
    ebusOpT     op;
    logic [1:0] unit;
    logic [1:0] regSel;
    ebusWordT   data;
  } ebusCmdT;

  // Read driver of one unit
  // The multiplexer looks at driving to decide who owns the bus this cycle
  typedef struct packed {
    logic     driving;
    ebusWordT data;
  } ebusDriverT;

endpackage

/* src/ebusTop.sv */
`timescale 1ns/1ps
`include "ebus_macros.svh"

module ebusTop
  import ebusPkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  ebusCmdT                   cmd,
  input  logic                      cmdStrobe,
  input  logic [0:`APR_ERR_COUNT-1] errIn,
  input  logic [1:`PI_LEVELS]       ioReq,
  output ebusWordT                  ebusData,
  output logic                      ebusValid,
  output logic [0:2]                piLevel,
  output logic                      piActive
);

  // Read drivers of the two units, merged by the multiplexer below
  ebusDriverT aprDriver;
  ebusDriverT piDriver;

  // APR interrupt request and the level it asks for
  logic       aprInt;
  logic [0:2] aprLevel;

  aprUnit apr0 (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmdStrobe (cmdStrobe),
    .errIn     (errIn),
    .aprDriver (aprDriver),
    .aprInt    (aprInt),
    .aprLevel  (aprLevel)
  );

  piUnit pi0 (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmdStrobe (cmdStrobe),
    .ioReq     (ioReq),
    .aprInt    (aprInt),
    .aprLevel  (aprLevel),
    .piDriver  (piDriver),
    .piLevel   (piLevel),
    .piActive  (piActive)
  );

  ebusMux mux0 (
    .aprDriver (aprDriver),
    .piDriver  (piDriver),
    .ebusData  (ebusData),
    .ebusValid (ebusValid),
    .clk       (clk)
  );

endmodule

/* src/ebus_macros.svh */
`ifndef EBUS_MACROS_SVH
`define EBUS_MACROS_SVH

// EBUS word width, numbered big-endian from bit 0 to bit 35
`define EBUS_WIDTH 36

// Number of sticky error flags held by the APR status unit
`define APR_ERR_COUNT 6

// Priority-interrupt levels, level 1 being the most urgent
`define PI_LEVELS 7

// Unit codes carried in the command; codes 2 and 3 select nothing
`define UNIT_APR 2'd0
`define UNIT_PI  2'd1

`endif

/* src/piUnit.sv */
`timescale 1ns/1ps
`include "ebus_macros.svh"

module piUnit
  import ebusPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  ebusCmdT               cmd,
  input  logic                  cmdStrobe,
  input  logic [1:`PI_LEVELS]   ioReq,
  input  logic                  aprInt,
  input  logic [0:2]            aprLevel,
  output ebusDriverT            piDriver,
  output logic [0:2]            piLevel,
  output logic                  piActive
);

  logic [1:`PI_LEVELS] levelEnable;
  logic                sysEnable;
  logic [1:`PI_LEVELS] softReq;
  logic [1:`PI_LEVELS] aprReq;
  logic [1:`PI_LEVELS] pending;
  logic [1:`PI_LEVELS] eligible;
  logic [0:2]          nextLevel;

  logic     writeHit;
  logic     readHit;
  ebusWordT readWord;
  logic     respDriving;
  ebusWordT respData;

  assign writeHit = cmdStrobe && (cmd.op == opWrite) && (cmd.unit == `UNIT_PI);
  assign readHit  = cmdStrobe && (cmd.op == opRead) && (cmd.unit == `UNIT_PI);

  always_ff @(posedge clk) begin
    if (reset) begin
      levelEnable <= '0;
      sysEnable   <= 1'b0;
      softReq     <= '0;
    end else if (writeHit) begin
      if (cmd.regSel == 2'd0) begin
        levelEnable <= cmd.data[29:35];
        sysEnable   <= cmd.data[28];
      end else if (cmd.regSel == 2'd1) begin
        softReq <= cmd.data[29:35];
      end
    end
  end

  // The APR asks at its programmed level; level 0 never matches here
  always_comb begin
    aprReq = '0;
    for (int lvl = 1; lvl <= `PI_LEVELS; lvl++) begin
      aprReq[lvl] = aprInt && (aprLevel == 3'(lvl));
    end
  end

  assign pending  = ioReq | softReq | aprReq;
  assign eligible = pending & levelEnable & {`PI_LEVELS{sysEnable}};

  // Scan from the bottom so the lowest-numbered eligible level is left standing
  always_comb begin
    nextLevel = '0;
    for (int lvl = `PI_LEVELS; lvl >= 1; lvl--) begin
      if (eligible[lvl]) nextLevel = 3'(lvl);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      piLevel  <= '0;
      piActive <= 1'b0;
    end else begin
      piLevel  <= nextLevel;
      piActive <= |nextLevel;
    end
  end

  always_comb begin
    readWord = '0;
    case (cmd.regSel)
      2'd0: begin
        readWord[28]    = sysEnable;
        readWord[29:35] = levelEnable;
      end
      2'd1: begin
        readWord[22:28] = pending;
        readWord[29:35] = softReq;
      end
      2'd2: readWord[33:35] = piLevel;
      default: readWord = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      respDriving <= 1'b0;
    end else begin
      respDriving <= readHit;
    end
  end

  always_ff @(posedge clk) begin
    if (readHit) begin
      respData <= readWord;
    end
  end

  assign piDriver = '{driving: respDriving, data: respData};

  // No level may be reported while the system enable was off
  piQuietWhenDisabled: assert property (@(posedge clk) disable iff (reset)
    !$past(sysEnable) |-> (piLevel == 3'd0) && !piActive)
    else $error("piUnit reports level %0d with the system enable off", piLevel);

endmodule

/* testbench/ebusTb.sv */
`timescale 1ns/1ps
`include "ebus_macros.svh"

module ebusTb
  import ebusPkg::*;
();

  localparam int validTimeout = 8;

  logic       clk = 1'b0;
  logic       reset;
  ebusCmdT    cmd;
  logic       cmdStrobe;
  logic [0:5] errIn;
  logic [1:7] ioReq;
  ebusWordT   ebusData;
  logic       ebusValid;
  logic [0:2] piLevel;
  logic       piActive;

  integer seed = 94724;
  int     errorCount = 0;

  // Reference copy of every register in both units
  logic [0:5] modelFlags;
  logic [0:5] modelEnable;
  logic [0:2] modelAprLevel;
  logic [1:7] modelLevelEnable;
  logic       modelSysEnable;
  logic [1:7] modelSoftReq;
  logic [0:2] modelPiLevel;
  logic       modelValid;
  ebusWordT   modelData;
  logic       modelAprInt;
  logic [1:7] modelAprReq;
  logic [1:7] modelPending;
  logic [0:5] modelClear;
  logic       aprWrite;
  logic       piWrite;

  always #20 clk = ~clk;

  ebusTop uut (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmdStrobe (cmdStrobe),
    .errIn     (errIn),
    .ioReq     (ioReq),
    .ebusData  (ebusData),
    .ebusValid (ebusValid),
    .piLevel   (piLevel),
    .piActive  (piActive)
  );

  function automatic logic [0:2] lowestLevel(input logic [1:7] req);
    logic [0:2] found;
    found = 3'd0;
    for (int i = 1; i <= 7; i++) begin
      if (req[i] && found == 3'd0) found = i[2:0];
    end
    return found;
  endfunction

  // Word a read of the given register should put on the bus
  function automatic ebusWordT expectedWord(input logic [1:0] unit, input logic [1:0] regSel);
    ebusWordT w;
    w = '0;
    if (unit == `UNIT_APR && regSel == 2'd0) begin
      w[30:35] = modelFlags;
    end else if (unit == `UNIT_APR && regSel == 2'd1) begin
      w[0:5]   = modelEnable;
      w[33:35] = modelAprLevel;
    end else if (unit == `UNIT_PI && regSel == 2'd0) begin
      w[28]    = modelSysEnable;
      w[29:35] = modelLevelEnable;
    end else if (unit == `UNIT_PI && regSel == 2'd1) begin
      w[22:28] = modelPending;
      w[29:35] = modelSoftReq;
    end else if (unit == `UNIT_PI && regSel == 2'd2) begin
      w[33:35] = modelPiLevel;
    end
    return w;
  endfunction

  assign aprWrite    = cmdStrobe && cmd.op == opWrite && cmd.unit == `UNIT_APR;
  assign piWrite     = cmdStrobe && cmd.op == opWrite && cmd.unit == `UNIT_PI;
  assign modelClear  = (aprWrite && cmd.regSel == 2'd0) ? cmd.data[30:35] : 6'b0;
  assign modelAprInt = |(modelFlags & modelEnable);
  // A one-hot request at the APR level, shifted down from level 1
  assign modelAprReq = (modelAprInt && modelAprLevel != 3'd0) ?
                       (7'b1000000 >> (modelAprLevel - 3'd1)) : 7'b0;
  assign modelPending = ioReq | modelSoftReq | modelAprReq;

  always @(posedge clk) begin
    if (reset) begin
      modelFlags       <= '0;
      modelEnable      <= '0;
      modelAprLevel    <= '0;
      modelLevelEnable <= '0;
      modelSysEnable   <= 1'b0;
      modelSoftReq     <= '0;
      modelPiLevel     <= '0;
      modelValid       <= 1'b0;
      modelData        <= '0;
    end else begin
      modelFlags <= (modelFlags & ~modelClear) | errIn;
      if (aprWrite && cmd.regSel == 2'd1) begin
        modelEnable   <= cmd.data[0:5];
        modelAprLevel <= cmd.data[33:35];
      end
      if (piWrite && cmd.regSel == 2'd0) begin
        modelLevelEnable <= cmd.data[29:35];
        modelSysEnable   <= cmd.data[28];
      end
      if (piWrite && cmd.regSel == 2'd1) modelSoftReq <= cmd.data[29:35];
      modelPiLevel <= modelSysEnable ? lowestLevel(modelPending & modelLevelEnable) : 3'd0;
      if (cmdStrobe && cmd.op == opRead && (cmd.unit == `UNIT_APR || cmd.unit == `UNIT_PI)) begin
        modelValid <= 1'b1;
        modelData  <= expectedWord(cmd.unit, cmd.regSel);
      end else begin
        modelValid <= 1'b0;
        modelData  <= '0;
      end
    end
  end

  validCheck: assert property (@(posedge clk) disable iff (reset) ebusValid == modelValid)
    else begin
      errorCount++;
      $display("[FAIL] %0t ebusValid expected %0b got %0b",
               $time, $sampled(modelValid), $sampled(ebusValid));
    end

  dataCheck: assert property (@(posedge clk) disable iff (reset) ebusData == modelData)
    else begin
      errorCount++;
      $display("[FAIL] %0t ebusData expected %h got %h",
               $time, $sampled(modelData), $sampled(ebusData));
    end

  levelCheck: assert property (@(posedge clk) disable iff (reset) piLevel == modelPiLevel)
    else begin
      errorCount++;
      $display("[FAIL] %0t piLevel expected %0d got %0d",
               $time, $sampled(modelPiLevel), $sampled(piLevel));
    end

  activeCheck: assert property (@(posedge clk) disable iff (reset)
    piActive == (modelPiLevel != 3'd0))
    else begin
      errorCount++;
      $display("[FAIL] %0t piActive expected %0b got %0b",
               $time, $sampled(modelPiLevel != 3'd0), $sampled(piActive));
    end

  function automatic logic [31:0] randBits();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic ebusWordT randWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = randBits();
    lo = randBits();
    return {hi[3:0], lo};
  endfunction

  // Every task starts and ends 1 ns after a rising edge
  task automatic issueCmd(input ebusOpT opCode, input logic [1:0] unit,
                          input logic [1:0] regSel, input ebusWordT data);
    cmd       = '{op: opCode, unit: unit, regSel: regSel, data: data};
    cmdStrobe = 1'b1;
    @(posedge clk);
    #1;
    cmdStrobe = 1'b0;
    cmd.op    = opNone;
  endtask

  task automatic waitValid(input logic [1:0] unit, input logic [1:0] regSel);
    int waited;
    waited = 0;
    while (!ebusValid && waited < validTimeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!ebusValid) begin
      errorCount++;
      $display("Timeout: no EBUS response to the read of unit %0d register %0d", unit, regSel);
    end
  endtask

  task automatic readReg(input logic [1:0] unit, input logic [1:0] regSel);
    issueCmd(opRead, unit, regSel, '0);
    if (unit == `UNIT_APR || unit == `UNIT_PI) waitValid(unit, regSel);
  endtask

  task automatic idleCycles(input int count);
    repeat (count) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic pulseErr(input logic [0:5] bits);
    errIn = bits;
    idleCycles(1);
    errIn = '0;
  endtask

  task automatic applyReset();
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic readAll();
    readReg(`UNIT_APR, 2'd0);
    readReg(`UNIT_APR, 2'd1);
    readReg(`UNIT_PI, 2'd0);
    readReg(`UNIT_PI, 2'd1);
    readReg(`UNIT_PI, 2'd2);
  endtask

  initial begin
    ebusWordT    word;
    logic [31:0] bits;
    cmd       = '{op: opNone, unit: 2'd0, regSel: 2'd0, data: '0};
    cmdStrobe = 1'b0;
    errIn     = '0;
    ioReq     = '0;
    applyReset();
    readAll();

    // Register round trips, plus reads of the two empty unit codes
    repeat (6) begin
      writeAndCheck: begin
        issueCmd(opWrite, `UNIT_APR, 2'd1, randWord());
        readReg(`UNIT_APR, 2'd1);
        issueCmd(opWrite, `UNIT_PI, 2'd0, randWord());
        readReg(`UNIT_PI, 2'd0);
        issueCmd(opWrite, `UNIT_PI, 2'd1, randWord());
        readReg(`UNIT_PI, 2'd1);
        readReg(`UNIT_PI, 2'd2);
        bits = randBits();
        readReg(2'd2, bits[1:0]);
        readReg(2'd3, bits[3:2]);
      end
    end

    // Sticky flags with write-one-to-clear
    repeat (10) begin
      bits = randBits();
      pulseErr(bits[5:0] & bits[11:6]);
      readReg(`UNIT_APR, 2'd0);
      word = '0;
      word[30:35] = bits[17:12];
      issueCmd(opWrite, `UNIT_APR, 2'd0, word);
      readReg(`UNIT_APR, 2'd0);
    end
    // A set landing together with a full clear keeps its flag
    word = '0;
    word[30:35] = 6'b111111;
    errIn = 6'b101010;
    issueCmd(opWrite, `UNIT_APR, 2'd0, word);
    errIn = '0;
    readReg(`UNIT_APR, 2'd0);
    issueCmd(opWrite, `UNIT_APR, 2'd0, word);

    // Level encoding with the system enable on, then off
    for (int pass = 0; pass < 2; pass++) begin
      repeat (12) begin
        word = randWord();
        word[28] = (pass == 0);
        issueCmd(opWrite, `UNIT_PI, 2'd0, word);
        issueCmd(opWrite, `UNIT_PI, 2'd1, randWord());
        bits = randBits();
        ioReq = bits[6:0];
        idleCycles(2);
        readReg(`UNIT_PI, 2'd2);
      end
    end

    // APR interrupt at every level, then with level 0 and with the flag masked
    ioReq = '0;
    issueCmd(opWrite, `UNIT_PI, 2'd1, '0);
    word = '0;
    word[28:35] = 8'hFF;
    issueCmd(opWrite, `UNIT_PI, 2'd0, word);
    for (int lvl = 0; lvl <= 8; lvl++) begin
      word = '0;
      word[0:5]   = (lvl == 8) ? 6'b110111 : 6'b111111;
      word[33:35] = (lvl == 8) ? 3'd3 : lvl[2:0];
      issueCmd(opWrite, `UNIT_APR, 2'd1, word);
      pulseErr(6'b001000);
      idleCycles(2);
      readReg(`UNIT_PI, 2'd1);
      readReg(`UNIT_PI, 2'd2);
      word = '0;
      word[30:35] = 6'b111111;
      issueCmd(opWrite, `UNIT_APR, 2'd0, word);
    end

    // Reads on consecutive cycles, alternating between the two units
    for (int k = 0; k < 8; k++) begin
      bits = randBits();
      issueCmd(opRead, k[0] ? `UNIT_PI : `UNIT_APR, bits[1:0], '0);
    end
    idleCycles(2);

    applyReset();
    readAll();
    idleCycles(2);

    $display("Checks finished with %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
